//--- design/dbg_axi_pkg.sv
package dbg_axi_pkg;

    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 64;
    localparam int STRB_BITS = DATA_BITS / 8;

    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_BITS = $clog2(MEM_WORDS);  // Word index taken above address bit 2

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] SIZE_8B = 3'd3;  // Eight bytes per beat
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Shared by AW and AR
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [7:0] len;  // Beats minus one
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ax_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic [STRB_BITS-1:0] strb;
        logic last;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic last;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic we;  // High for a write
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] wdata;
        logic [STRB_BITS-1:0] wstrb;
    } dbg_req_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] rdata;  // Zero for writes
    } dbg_resp_t;

endpackage

//--- design/axi_chan_slice.sv
`timescale 1ns/1ps

module axi_chan_slice #(
    parameter type payload_t = logic
) (
    input  logic clk,
    input  logic nrst,
    input  logic i_valid,
    input  payload_t i_data,
    output logic o_ready,
    output logic o_valid,
    output payload_t o_data,
    input  logic i_ready
);

    logic full;  // One item is held
    payload_t data_q;

    // A new item may enter while the held one leaves
    assign o_ready = !full || i_ready;
    assign o_valid = full;
    assign o_data = data_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            full <= 1'b0;
        end else if (o_ready) begin
            full <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            data_q <= i_data;
        end
    end

endmodule

//--- design/dbg_axi_master.sv
`timescale 1ns/1ps

module dbg_axi_master (
    input  logic clk,
    input  logic nrst,
    input  logic i_req_valid,
    input  dbg_axi_pkg::dbg_req_t i_req,
    output logic o_req_ready,
    output logic o_resp_valid,
    output dbg_axi_pkg::dbg_resp_t o_resp,
    output logic o_aw_valid,
    output dbg_axi_pkg::axi_ax_t o_aw,
    input  logic i_aw_ready,
    output logic o_w_valid,
    output dbg_axi_pkg::axi_w_t o_w,
    input  logic i_w_ready,
    output logic o_ar_valid,
    output dbg_axi_pkg::axi_ax_t o_ar,
    input  logic i_ar_ready,
    input  logic i_r_valid,
    input  dbg_axi_pkg::axi_r_t i_r,
    output logic o_r_ready,
    input  logic i_b_valid,
    input  dbg_axi_pkg::axi_b_t i_b,
    output logic o_b_ready
);

    import dbg_axi_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_RDATA,
        S_WDATA,
        S_WRESP
    } state_t;

    state_t state;
    state_t state_nxt;

    axi_ax_t req_ax;
    logic addr_phase;
    logic addr_taken;
    logic rd_done;
    logic wr_done;

    logic [1:0] hw_off;  // Halfword offset of the pending read
    logic [7:0] burst_len;
    logic [7:0] burst_cnt;
    logic [2*DATA_BITS-1:0] burst_buf;
    logic [2*DATA_BITS-1:0] buf_nxt;
    logic [DATA_BITS-1:0] w_data;
    logic [STRB_BITS-1:0] w_strb;

    // Picks the host word out of one or two received beats
    function automatic logic [DATA_BITS-1:0] pick_rdata(
        input logic [1:0] off,
        input logic [2*DATA_BITS-1:0] buf_in
    );
        logic [DATA_BITS-1:0] res;
        case (off)
            2'b00: res = buf_in[DATA_BITS-1:0];
            2'b01: res = {16'd0, buf_in[DATA_BITS-1:16]};
            2'b10: res = {32'd0, buf_in[DATA_BITS-1:32]};
            default: res = {buf_in[DATA_BITS-17:0], buf_in[2*DATA_BITS-1 -: 16]};
        endcase
        return res;
    endfunction

    // Writes are always one aligned beat and only a read at offset 3 needs two
    always_comb begin
        req_ax.addr = {i_req.addr[ADDR_BITS-1:3], 3'b000};
        req_ax.size = SIZE_8B;
        req_ax.len = 8'd0;
        req_ax.burst = BURST_FIXED;
        if (!i_req.we && i_req.addr[2:1] == 2'b11) begin
            req_ax.len = 8'd1;
            req_ax.burst = BURST_INCR;
        end
    end

    assign addr_phase = (state == S_IDLE || state == S_ADDR) && i_req_valid;
    assign o_aw_valid = addr_phase && i_req.we;
    assign o_ar_valid = addr_phase && !i_req.we;
    assign o_aw = req_ax;
    assign o_ar = req_ax;
    assign addr_taken = (o_aw_valid && i_aw_ready) || (o_ar_valid && i_ar_ready);
    assign o_req_ready = addr_taken;  // Host request is consumed with the address

    assign o_w_valid = (state == S_WDATA);
    assign o_w = '{data: w_data, strb: w_strb, last: 1'b1};

    assign o_r_ready = 1'b1;
    assign o_b_ready = 1'b1;

    assign buf_nxt = {burst_buf[DATA_BITS-1:0], i_r.data};  // Newest beat lands low
    assign rd_done = (state == S_RDATA) && i_r_valid && (burst_cnt == burst_len);
    assign wr_done = (state == S_WRESP) && i_b_valid && (i_b.resp == RESP_OKAY);

    assign o_resp_valid = rd_done || wr_done;
    assign o_resp.rdata = rd_done ? pick_rdata(hw_off, buf_nxt) : '0;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE, S_ADDR: begin
                if (addr_taken) begin
                    state_nxt = i_req.we ? S_WDATA : S_RDATA;
                end else if (i_req_valid) begin
                    state_nxt = S_ADDR;  // Slice is full so the address stays up
                end else begin
                    state_nxt = S_IDLE;
                end
            end
            S_RDATA: begin
                if (rd_done) begin
                    state_nxt = S_IDLE;
                end
            end
            S_WDATA: begin
                if (i_w_ready) begin
                    state_nxt = S_WRESP;
                end
            end
            S_WRESP: begin
                if (i_b_valid) begin
                    state_nxt = S_IDLE;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_taken) begin
            hw_off <= i_req.addr[2:1];
            burst_len <= req_ax.len;
            burst_cnt <= 8'd0;
            burst_buf <= '0;
            w_data <= i_req.wdata;
            w_strb <= i_req.wstrb;
        end else if (state == S_RDATA && i_r_valid) begin
            burst_buf <= buf_nxt;
            burst_cnt <= burst_cnt + 8'd1;
        end
    end

endmodule

//--- design/axi_sram.sv
`timescale 1ns/1ps

module axi_sram (
    input  logic clk,
    input  logic nrst,
    input  logic i_aw_valid,
    input  dbg_axi_pkg::axi_ax_t i_aw,
    output logic o_aw_ready,
    input  logic i_w_valid,
    input  dbg_axi_pkg::axi_w_t i_w,
    output logic o_w_ready,
    output logic o_b_valid,
    output dbg_axi_pkg::axi_b_t o_b,
    input  logic i_b_ready,
    input  logic i_ar_valid,
    input  dbg_axi_pkg::axi_ax_t i_ar,
    output logic o_ar_ready,
    output logic o_r_valid,
    output dbg_axi_pkg::axi_r_t o_r,
    input  logic i_r_ready
);

    import dbg_axi_pkg::*;

    logic [DATA_BITS-1:0] mem [MEM_WORDS];

    logic rd_busy;
    logic rd_incr;
    logic [MEM_IDX_BITS-1:0] rd_idx;
    logic [7:0] rd_left;  // Beats still to send after the current one

    logic aw_full;
    logic wr_incr;
    logic [MEM_IDX_BITS-1:0] wr_idx;
    logic b_valid;
    logic w_take;

    assign o_ar_ready = !rd_busy;
    assign o_r_valid = rd_busy;
    assign o_r.data = mem[rd_idx];
    assign o_r.last = (rd_left == 8'd0);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rd_busy <= 1'b0;
        end else if (i_ar_valid && !rd_busy) begin
            rd_busy <= 1'b1;
        end else if (rd_busy && i_r_ready && rd_left == 8'd0) begin
            rd_busy <= 1'b0;
        end
    end

    // Word index wraps within the memory depth
    always_ff @(posedge clk) begin
        if (i_ar_valid && !rd_busy) begin
            rd_idx <= i_ar.addr[MEM_IDX_BITS+2:3];
            rd_left <= i_ar.len;
            rd_incr <= (i_ar.burst == BURST_INCR);
        end else if (rd_busy && i_r_ready && rd_left != 8'd0) begin
            rd_left <= rd_left - 8'd1;
            if (rd_incr) begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    // No new AW until the previous B has gone
    assign o_aw_ready = !aw_full && !b_valid;
    assign o_w_ready = aw_full;
    assign w_take = aw_full && i_w_valid;
    assign o_b_valid = b_valid;
    assign o_b.resp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            aw_full <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (i_aw_valid && o_aw_ready) begin
                aw_full <= 1'b1;
            end else if (w_take && i_w.last) begin
                aw_full <= 1'b0;
            end
            if (w_take && i_w.last) begin
                b_valid <= 1'b1;  // B follows the last W beat by one cycle
            end else if (i_b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_aw_valid && o_aw_ready) begin
            wr_idx <= i_aw.addr[MEM_IDX_BITS+2:3];
            wr_incr <= (i_aw.burst == BURST_INCR);
        end else if (w_take && wr_incr) begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (w_take) begin
            for (int i = 0; i < STRB_BITS; i++) begin
                if (i_w.strb[i]) begin
                    mem[wr_idx][i*8 +: 8] <= i_w.data[i*8 +: 8];
                end
            end
        end
    end

endmodule

//--- design/dbg_axi_top.sv
`timescale 1ns/1ps

module dbg_axi_top (
    input  logic clk,
    input  logic nrst,
    input  logic i_req_valid,
    input  dbg_axi_pkg::dbg_req_t i_req,
    output logic o_req_ready,
    output logic o_resp_valid,
    output dbg_axi_pkg::dbg_resp_t o_resp
);

    import dbg_axi_pkg::*;

    // Master side of each slice
    logic m_aw_valid, m_aw_ready;
    logic m_w_valid, m_w_ready;
    logic m_ar_valid, m_ar_ready;
    logic m_r_valid, m_r_ready;
    logic m_b_valid, m_b_ready;
    axi_ax_t m_aw, m_ar;
    axi_w_t m_w;
    axi_r_t m_r;
    axi_b_t m_b;

    // SRAM side of each slice
    logic s_aw_valid, s_aw_ready;
    logic s_w_valid, s_w_ready;
    logic s_ar_valid, s_ar_ready;
    logic s_r_valid, s_r_ready;
    logic s_b_valid, s_b_ready;
    axi_ax_t s_aw, s_ar;
    axi_w_t s_w;
    axi_r_t s_r;
    axi_b_t s_b;

    dbg_axi_master u_master (
        .clk(clk), .nrst(nrst),
        .i_req_valid(i_req_valid), .i_req(i_req), .o_req_ready(o_req_ready),
        .o_resp_valid(o_resp_valid), .o_resp(o_resp),
        .o_aw_valid(m_aw_valid), .o_aw(m_aw), .i_aw_ready(m_aw_ready),
        .o_w_valid(m_w_valid), .o_w(m_w), .i_w_ready(m_w_ready),
        .o_ar_valid(m_ar_valid), .o_ar(m_ar), .i_ar_ready(m_ar_ready),
        .i_r_valid(m_r_valid), .i_r(m_r), .o_r_ready(m_r_ready),
        .i_b_valid(m_b_valid), .i_b(m_b), .o_b_ready(m_b_ready)
    );

    axi_chan_slice #(.payload_t(axi_ax_t)) u_aw_slice (
        .clk(clk), .nrst(nrst),
        .i_valid(m_aw_valid), .i_data(m_aw), .o_ready(m_aw_ready),
        .o_valid(s_aw_valid), .o_data(s_aw), .i_ready(s_aw_ready)
    );

    axi_chan_slice #(.payload_t(axi_w_t)) u_w_slice (
        .clk(clk), .nrst(nrst),
        .i_valid(m_w_valid), .i_data(m_w), .o_ready(m_w_ready),
        .o_valid(s_w_valid), .o_data(s_w), .i_ready(s_w_ready)
    );

    axi_chan_slice #(.payload_t(axi_ax_t)) u_ar_slice (
        .clk(clk), .nrst(nrst),
        .i_valid(m_ar_valid), .i_data(m_ar), .o_ready(m_ar_ready),
        .o_valid(s_ar_valid), .o_data(s_ar), .i_ready(s_ar_ready)
    );

    // R and B run from the SRAM back to the master
    axi_chan_slice #(.payload_t(axi_r_t)) u_r_slice (
        .clk(clk), .nrst(nrst),
        .i_valid(s_r_valid), .i_data(s_r), .o_ready(s_r_ready),
        .o_valid(m_r_valid), .o_data(m_r), .i_ready(m_r_ready)
    );

    axi_chan_slice #(.payload_t(axi_b_t)) u_b_slice (
        .clk(clk), .nrst(nrst),
        .i_valid(s_b_valid), .i_data(s_b), .o_ready(s_b_ready),
        .o_valid(m_b_valid), .o_data(m_b), .i_ready(m_b_ready)
    );

    axi_sram u_sram (
        .clk(clk), .nrst(nrst),
        .i_aw_valid(s_aw_valid), .i_aw(s_aw), .o_aw_ready(s_aw_ready),
        .i_w_valid(s_w_valid), .i_w(s_w), .o_w_ready(s_w_ready),
        .o_b_valid(s_b_valid), .o_b(s_b), .i_b_ready(s_b_ready),
        .i_ar_valid(s_ar_valid), .i_ar(s_ar), .o_ar_ready(s_ar_ready),
        .o_r_valid(s_r_valid), .o_r(s_r), .i_r_ready(s_r_ready)
    );

endmodule

//--- testbench/dbg_axi_chk.sv
`timescale 1ns/1ps

module dbg_axi_chk (
    input  logic clk,
    input  logic nrst,
    input  logic i_req_valid,
    input  logic i_req_ready,
    input  logic i_resp_valid,
    input  logic i_aw_valid,
    input  logic i_aw_ready,
    input  dbg_axi_pkg::axi_ax_t i_aw,
    input  logic i_ar_valid,
    input  logic i_ar_ready,
    input  dbg_axi_pkg::axi_ax_t i_ar,
    input  logic [9:0] i_chan_valids
);

    int fails = 0;  // Failed assertions so far

    a_ready_needs_valid: assert property (@(posedge clk) disable iff (!nrst)
        i_req_ready |-> i_req_valid)
        else begin
            $error("o_req_ready went high while i_req_valid was low");
            fails++;
        end

    a_resp_single: assert property (@(posedge clk) disable iff (!nrst)
        i_resp_valid |=> !i_resp_valid)
        else begin
            $error("o_resp_valid stayed high for two cycles");
            fails++;
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (!nrst)
        (i_aw_valid && !i_aw_ready) |=> (i_aw_valid && $stable(i_aw)))
        else begin
            $error("AW dropped or changed before ready");
            fails++;
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (!nrst)
        (i_ar_valid && !i_ar_ready) |=> (i_ar_valid && $stable(i_ar)))
        else begin
            $error("AR dropped or changed before ready");
            fails++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        $rose(nrst) |-> (i_chan_valids == '0 && !i_req_ready && !i_resp_valid))
        else begin
            $error("A valid was high in the first cycle after reset");
            fails++;
        end

endmodule

bind dbg_axi_top dbg_axi_chk u_chk (
    .clk(clk), .nrst(nrst),
    .i_req_valid(i_req_valid), .i_req_ready(o_req_ready), .i_resp_valid(o_resp_valid),
    .i_aw_valid(m_aw_valid), .i_aw_ready(m_aw_ready), .i_aw(m_aw),
    .i_ar_valid(m_ar_valid), .i_ar_ready(m_ar_ready), .i_ar(m_ar),
    .i_chan_valids({m_aw_valid, m_w_valid, m_ar_valid, m_r_valid, m_b_valid,
                    s_aw_valid, s_w_valid, s_ar_valid, s_r_valid, s_b_valid})
);

//--- testbench/tb_dbg_axi.sv
`timescale 1ns/1ps

module tb_dbg_axi;

    import dbg_axi_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_REQ = 16 * 5 + 8 + 200;  // Directed phases plus the random mix
    localparam int CYCLE_LIMIT = 40 * NUM_REQ + RESET_CYCLES;

    logic clk;
    logic nrst;
    logic i_req_valid;
    dbg_req_t i_req;
    logic o_req_ready;
    logic o_resp_valid;
    dbg_resp_t o_resp;

    logic [63:0] model_mem [16];
    integer seed = 13;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int acc_count = 0;  // Requests the DUT took
    int resp_count = 0;
    int issued = 0;

    dbg_axi_top u_dbg_axi_top (
        .clk(clk), .nrst(nrst),
        .i_req_valid(i_req_valid), .i_req(i_req), .o_req_ready(o_req_ready),
        .o_resp_valid(o_resp_valid), .o_resp(o_resp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // Counts accepted requests and responses
    always @(negedge clk) begin
        if (nrst && o_req_ready) acc_count++;
        if (nrst && o_resp_valid) resp_count++;
    end

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    // A read at offset 3 joins the top halfword of word n with the low six bytes of n+1
    function automatic logic [63:0] expect_read(input logic [3:0] word, input logic [1:0] off);
        logic [63:0] cur;
        logic [63:0] nxt;
        cur = model_mem[word];
        nxt = model_mem[word + 4'd1];
        case (off)
            2'd0: return cur;
            2'd1: return cur >> 16;
            2'd2: return cur >> 32;
            default: return {nxt[47:0], cur[63:48]};
        endcase
    endfunction

    task automatic run_req(input string name, input logic we, input logic [3:0] word,
                           input logic [1:0] off, input logic [63:0] wdata,
                           input logic [7:0] wstrb);
        logic [63:0] exp;
        exp = we ? 64'd0 : expect_read(word, off);
        if (we) begin
            for (int i = 0; i < 8; i++) begin
                if (wstrb[i]) model_mem[word][i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        @(posedge clk);
        i_req_valid <= 1'b1;
        i_req <= '{we: we, addr: {25'd0, word, off, 1'b0}, wdata: wdata, wstrb: wstrb};
        @(negedge clk);
        while (!o_req_ready) @(negedge clk);
        @(posedge clk);
        i_req_valid <= 1'b0;  // Taken at this edge
        @(negedge clk);
        while (!o_resp_valid) @(negedge clk);
        compare(name, exp, o_resp.rdata);
        issued++;
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0] word;
        logic [1:0] off;
        nrst = 1'b0;
        i_req_valid = 1'b0;
        i_req = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            compare("idle_req_ready", 64'd0, {63'd0, o_req_ready});
            compare("idle_resp_valid", 64'd0, {63'd0, o_resp_valid});
        end
        for (int w = 0; w < 16; w++) run_req("init_write", 1'b1, w, 2'd0,
                                             {$random(seed), $random(seed)}, 8'hff);
        for (int w = 0; w < 16; w++) run_req("init_read", 1'b0, w, 2'd0, '0, '0);
        for (int w = 0; w < 16; w++) run_req("strb_write", 1'b1, w, 2'd0,
                                             {$random(seed), $random(seed)}, $random(seed));
        for (int w = 0; w < 16; w++) run_req("strb_read", 1'b0, w, 2'd0, '0, '0);
        for (int w = 0; w < 16; w++) run_req("shift_read", 1'b0, w, 2'd1 + w[0], '0, '0);
        repeat (8) begin
            r = $random(seed);
            word = (r[3:0] == 4'd15) ? 4'd14 : r[3:0];  // Model holds no word 16
            run_req("split_read", 1'b0, word, 2'd3, '0, '0);
        end
        repeat (200) begin
            r = $random(seed);
            word = r[7:4];
            off = r[9:8];
            if (!r[0] && off == 2'd3 && word == 4'd15) word = 4'd14;
            repeat (r[27:26]) @(posedge clk);
            run_req(r[0] ? "mix_write" : "mix_read", r[0], word, off,
                    {$random(seed), $random(seed)}, r[23:16]);
        end
        repeat (4) @(posedge clk);
        compare("accepted_count", issued, acc_count);
        compare("response_count", acc_count, resp_count);
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 checks, errors, u_dbg_axi_top.u_chk.fails);
        if (errors == 0 && u_dbg_axi_top.u_chk.fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dbg_axi.f
design/dbg_axi_pkg.sv
design/axi_chan_slice.sv
design/dbg_axi_master.sv
design/axi_sram.sv
design/dbg_axi_top.sv
testbench/dbg_axi_chk.sv
testbench/tb_dbg_axi.sv

//--- Bender.yml
package:
  name: dbg_axi

sources:
  - design/dbg_axi_pkg.sv
  - design/axi_chan_slice.sv
  - design/dbg_axi_master.sv
  - design/axi_sram.sv
  - design/dbg_axi_top.sv
  - target: test
    files:
      - testbench/dbg_axi_chk.sv
      - testbench/tb_dbg_axi.sv
